//--- logic/ps2_pkg.sv
package ps2_pkg;

    // one byte from the frame receiver, valid for a single cycle
    typedef struct packed {
        logic       valid;
        logic [7:0] code;
    } scan_byte_t;

    // decoded key event, released marks a break code
    typedef struct packed {
        logic       valid;
        logic       released;
        logic [7:0] code;
    } key_event_t;

    // frame receiver states
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_SHIFT,
        RX_CHECK
    } rx_state_e;

    // decoder states
    typedef enum logic [1:0] {
        DEC_WAIT,
        DEC_MAKE,
        DEC_BREAK_WAIT,
        DEC_BREAK
    } dec_state_e;

    // prefix byte sent by the keyboard ahead of a break code
    localparam logic [7:0] BREAK_PREFIX = 8'hF0;

endpackage

//--- logic/ps2_frame_rx.sv
`timescale 1ns/1ps

module ps2_frame_rx #(
    parameter int IDLE_TIMEOUT = 2000
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                ps2_clk,
    input  logic                ps2_dat,
    output ps2_pkg::scan_byte_t rx_byte,
    output logic                frame_error
);

    localparam int IW = $clog2(IDLE_TIMEOUT + 1);

    logic [1:0]         clk_sync;
    logic [1:0]         dat_sync;
    logic               clk_prev;
    logic               fall;
    ps2_pkg::rx_state_e state;
    logic [3:0]         bit_cnt;
    logic [IW-1:0]      idle_cnt;
    logic [9:0]         shreg;
    logic               stop_bit;
    logic               frame_ok;

    // two-flop synchronizers, idle lines sit high
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end
        else
        begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    assign fall = clk_prev & ~clk_sync[1];

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            state    <= ps2_pkg::RX_IDLE;
            bit_cnt  <= '0;
            idle_cnt <= '0;
        end
        else
        begin
            case (state)
                ps2_pkg::RX_IDLE:
                begin
                    idle_cnt <= '0;
                    if (fall)
                    begin
                        bit_cnt <= 4'd1;
                        state   <= ps2_pkg::RX_SHIFT;
                    end
                end
                ps2_pkg::RX_SHIFT:
                begin
                    if (fall)
                    begin
                        idle_cnt <= '0;
                        bit_cnt  <= bit_cnt + 4'd1;
                        if (bit_cnt == 4'd10)
                            state <= ps2_pkg::RX_CHECK;
                    end
                    else if (!clk_sync[1])
                        idle_cnt <= '0;
                    else if (idle_cnt == IW'(IDLE_TIMEOUT))
                        // keyboard went quiet mid frame, drop it
                        state <= ps2_pkg::RX_IDLE;
                    else
                        idle_cnt <= idle_cnt + IW'(1);
                end
                default:
                    state <= ps2_pkg::RX_IDLE;
            endcase
        end
    end

    // start, data and parity shift in lsb first, the stop bit is kept apart
    always_ff @(posedge clk)
    begin
        if (fall && state != ps2_pkg::RX_CHECK)
        begin
            if (state == ps2_pkg::RX_SHIFT && bit_cnt == 4'd10)
                stop_bit <= dat_sync[1];
            else
                shreg <= {dat_sync[1], shreg[9:1]};
        end
    end

    // odd parity over data plus parity bit
    assign frame_ok = ~shreg[0] & (^shreg[9:1]) & stop_bit;

    assign rx_byte = '{valid: (state == ps2_pkg::RX_CHECK) && frame_ok,
                       code:  shreg[8:1]};
    assign frame_error = (state == ps2_pkg::RX_CHECK) && !frame_ok;

endmodule

//--- logic/scan_fifo.sv
`timescale 1ns/1ps

module scan_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  ps2_pkg::scan_byte_t rx_byte,
    input  logic                next_n,
    output logic                ready,
    output logic [7:0]          data,
    output logic                overflow
);

    localparam int AW = $clog2(FIFO_DEPTH);
    localparam logic [AW:0] FULL_COUNT = FIFO_DEPTH[AW:0];

    logic [7:0]    mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          full;
    logic          pop;
    logic          wr_en;

    assign full  = (count == FULL_COUNT);
    assign pop   = ~next_n & ready;
    // a pop in the same cycle frees the slot for the incoming byte
    assign wr_en = rx_byte.valid & (~full | pop);

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_ptr] <= rx_byte.code;
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            if (rx_byte.valid && !wr_en)
                overflow <= 1'b1;
        end
    end

    assign ready = (count != '0);
    assign data  = mem[rd_ptr];

endmodule

//--- logic/key_decoder.sv
`timescale 1ns/1ps

module key_decoder (
    input  logic                clk,
    input  logic                rst,
    input  logic                ready,
    input  logic [7:0]          data,
    output logic                next_n,
    output ps2_pkg::key_event_t key_event
);

    ps2_pkg::dec_state_e state;
    logic                pop;
    logic                ev_valid;
    logic                ev_released;
    logic [7:0]          ev_code;

    // head byte is inspected in the same cycle it is popped
    assign pop    = ready && (state == ps2_pkg::DEC_WAIT ||
                              state == ps2_pkg::DEC_BREAK_WAIT);
    assign next_n = ~pop;

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            state    <= ps2_pkg::DEC_WAIT;
            ev_valid <= 1'b0;
        end
        else
        begin
            ev_valid <= 1'b0;
            case (state)
                ps2_pkg::DEC_WAIT:
                begin
                    if (ready)
                    begin
                        if (data == ps2_pkg::BREAK_PREFIX)
                            state <= ps2_pkg::DEC_BREAK_WAIT;
                        else
                        begin
                            ev_valid <= 1'b1;
                            state    <= ps2_pkg::DEC_MAKE;
                        end
                    end
                end
                ps2_pkg::DEC_MAKE:
                    state <= ps2_pkg::DEC_WAIT;
                ps2_pkg::DEC_BREAK_WAIT:
                begin
                    // a repeated prefix is folded into the pending break
                    if (ready && data != ps2_pkg::BREAK_PREFIX)
                    begin
                        ev_valid <= 1'b1;
                        state    <= ps2_pkg::DEC_BREAK;
                    end
                end
                ps2_pkg::DEC_BREAK:
                    state <= ps2_pkg::DEC_WAIT;
                default:
                    state <= ps2_pkg::DEC_WAIT;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (pop)
        begin
            ev_code     <= data;
            ev_released <= (state == ps2_pkg::DEC_BREAK_WAIT);
        end
    end

    assign key_event = '{valid:    ev_valid,
                         released: ev_released,
                         code:     ev_code};

endmodule

//--- logic/seg7_display.sv
`timescale 1ns/1ps

module seg7_display (
    input  logic                clk,
    input  logic                rst,
    input  ps2_pkg::key_event_t key_event,
    output logic [7:0]          seg_lo,
    output logic [7:0]          seg_hi
);

    logic [7:0] code_q;
    logic       shown;

    // hex glyph, segments g..a, active low
    function automatic logic [6:0] hex_glyph(input logic [3:0] nib);
        logic [6:0] lit;
        case (nib)
            4'h0: lit = 7'h3F;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5B;
            4'h3: lit = 7'h4F;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6D;
            4'h6: lit = 7'h7D;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7F;
            4'h9: lit = 7'h6F;
            4'hA: lit = 7'h77;
            4'hB: lit = 7'h7C;
            4'hC: lit = 7'h39;
            4'hD: lit = 7'h5E;
            4'hE: lit = 7'h79;
            default: lit = 7'h71;
        endcase
        return ~lit;
    endfunction

    always_ff @(posedge clk)
    begin
        if (!rst)
            shown <= 1'b0;
        else if (key_event.valid && !key_event.released)
            shown <= 1'b1;
    end

    // break events leave the display alone
    always_ff @(posedge clk)
    begin
        if (key_event.valid && !key_event.released)
            code_q <= key_event.code;
    end

    assign seg_lo = shown ? {1'b1, hex_glyph(code_q[3:0])} : 8'hFF;
    assign seg_hi = shown ? {1'b1, hex_glyph(code_q[7:4])} : 8'hFF;

endmodule

//--- logic/ps2_key_top.sv
`timescale 1ns/1ps

module ps2_key_top #(
    parameter int FIFO_DEPTH   = 8,
    parameter int IDLE_TIMEOUT = 2000
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                ps2_clk,
    input  logic                ps2_dat,
    output ps2_pkg::key_event_t key_event,
    output logic [7:0]          seg_lo,
    output logic [7:0]          seg_hi,
    output logic                overflow,
    output logic                frame_error
);

    ps2_pkg::scan_byte_t rx_byte;
    logic                fifo_ready;
    logic [7:0]          fifo_data;
    logic                next_n;

    ps2_frame_rx #(
        .IDLE_TIMEOUT(IDLE_TIMEOUT)
    ) u_frame_rx (
        .clk         (clk),
        .rst         (rst),
        .ps2_clk     (ps2_clk),
        .ps2_dat     (ps2_dat),
        .rx_byte     (rx_byte),
        .frame_error (frame_error)
    );

    scan_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .clk      (clk),
        .rst      (rst),
        .rx_byte  (rx_byte),
        .next_n   (next_n),
        .ready    (fifo_ready),
        .data     (fifo_data),
        .overflow (overflow)
    );

    key_decoder u_decoder (
        .clk       (clk),
        .rst       (rst),
        .ready     (fifo_ready),
        .data      (fifo_data),
        .next_n    (next_n),
        .key_event (key_event)
    );

    seg7_display u_display (
        .clk       (clk),
        .rst       (rst),
        .key_event (key_event),
        .seg_lo    (seg_lo),
        .seg_hi    (seg_hi)
    );

endmodule

//--- verif/ps2_key_tb.sv
`timescale 1ns/1ps

module ps2_key_tb;

    localparam int FIFO_DEPTH   = 8;
    localparam int IDLE_TIMEOUT = 2000;
    // keyboard clock half period in system clocks
    localparam int HALF_BIT     = 20;
    localparam int EVENT_LIMIT  = 1200;

    logic                clk;
    logic                rst;
    logic                ps2_clk;
    logic                ps2_dat;
    ps2_pkg::key_event_t key_event;
    logic [7:0]          seg_lo;
    logic [7:0]          seg_hi;
    logic                overflow;
    logic                frame_error;

    ps2_pkg::key_event_t ev_q[$];
    int                  err_pulses;

    ps2_key_top #(
        .FIFO_DEPTH   (FIFO_DEPTH),
        .IDLE_TIMEOUT (IDLE_TIMEOUT)
    ) dut (
        .clk         (clk),
        .rst         (rst),
        .ps2_clk     (ps2_clk),
        .ps2_dat     (ps2_dat),
        .key_event   (key_event),
        .seg_lo      (seg_lo),
        .seg_hi      (seg_hi),
        .overflow    (overflow),
        .frame_error (frame_error)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // record every event and error pulse seen after reset
    always @(posedge clk)
    begin
        if (rst)
        begin
            if (key_event.valid)
                ev_q.push_back(key_event);
            if (frame_error)
                err_pulses++;
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
            fail_run($sformatf("mismatch %s expected %0h actual %0h", name, expected, actual));
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // active-low hex glyph with dp off in bit order dp g f e d c b a
    function automatic logic [7:0] seg_glyph(input logic [3:0] nib);
        logic [7:0] g;
        case (nib)
            4'h0: g = 8'hC0;
            4'h1: g = 8'hF9;
            4'h2: g = 8'hA4;
            4'h3: g = 8'hB0;
            4'h4: g = 8'h99;
            4'h5: g = 8'h92;
            4'h6: g = 8'h82;
            4'h7: g = 8'hF8;
            4'h8: g = 8'h80;
            4'h9: g = 8'h90;
            4'hA: g = 8'h88;
            4'hB: g = 8'h83;
            4'hC: g = 8'hC6;
            4'hD: g = 8'hA1;
            4'hE: g = 8'h86;
            default: g = 8'h8E;
        endcase
        return g;
    endfunction

    function automatic logic [7:0] random_code();
        logic [7:0] c;
        c = 8'($urandom_range(0, 255));
        while (c == 8'hF0)
            c = 8'($urandom_range(0, 255));
        return c;
    endfunction

    // keyboard model sends start bit, data lsb first, parity and stop
    task automatic send_frame(input logic [7:0] code, input logic bad_parity, input int nbits);
        logic [10:0] bits;
        int          i;
        bits = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
        for (i = 0; i < nbits; i++)
        begin
            @(posedge clk);
            ps2_dat <= bits[i];
            wait_cycles(HALF_BIT);
            ps2_clk <= 1'b0;
            wait_cycles(HALF_BIT);
            ps2_clk <= 1'b1;
        end
        @(posedge clk);
        ps2_dat <= 1'b1;
    endtask

    task automatic next_event(output ps2_pkg::key_event_t ev, input string name);
        int waited;
        waited = 0;
        while (ev_q.size() == 0)
        begin
            if (waited >= EVENT_LIMIT)
                fail_run($sformatf("%s: no key event arrived within %0d cycles",
                                   name, EVENT_LIMIT));
            else
            begin
                @(posedge clk);
                waited++;
            end
        end
        ev = ev_q.pop_front();
    endtask

    task automatic catch_frame_error(input int expected, input string name);
        int waited;
        waited = 0;
        while (err_pulses < expected)
        begin
            if (waited >= EVENT_LIMIT)
                fail_run($sformatf("%s: no frame error pulse within %0d cycles",
                                   name, EVENT_LIMIT));
            else
            begin
                @(posedge clk);
                waited++;
            end
        end
    endtask

    task automatic expect_make(input logic [7:0] code, input string name);
        ps2_pkg::key_event_t ev;
        next_event(ev, name);
        check_equal({name, " released"}, 32'(1'b0), 32'(ev.released));
        check_equal({name, " code"}, 32'(code), 32'(ev.code));
        // display register follows one cycle behind the event
        wait_cycles(2);
        check_equal({name, " seg_lo"}, 32'(seg_glyph(code[3:0])), 32'(seg_lo));
        check_equal({name, " seg_hi"}, 32'(seg_glyph(code[7:4])), 32'(seg_hi));
    endtask

    task automatic verify_reset_state();
        check_equal("reset seg_lo", 32'hFF, 32'(seg_lo));
        check_equal("reset seg_hi", 32'hFF, 32'(seg_hi));
        check_equal("reset overflow", 32'(1'b0), 32'(overflow));
        wait_cycles(100);
        check_equal("reset events", 32'd0, 32'(ev_q.size()));
        check_equal("reset frame errors", 32'd0, 32'(err_pulses));
    endtask

    task automatic decode_make_codes();
        logic [7:0] code;
        int         i;
        for (i = 0; i < 6; i++)
        begin
            code = random_code();
            send_frame(code, 1'b0, 11);
            expect_make(code, "make codes");
        end
    endtask

    task automatic decode_break_codes();
        ps2_pkg::key_event_t ev;
        logic [7:0]          code;
        logic [7:0]          other;
        code  = random_code();
        other = random_code();
        while (other == code)
            other = random_code();
        send_frame(code, 1'b0, 11);
        expect_make(code, "break codes first make");
        send_frame(other, 1'b0, 11);
        expect_make(other, "break codes second make");
        // releasing the first key must leave the second key on the digits
        send_frame(8'hF0, 1'b0, 11);
        send_frame(code, 1'b0, 11);
        next_event(ev, "break codes");
        check_equal("break codes released", 32'(1'b1), 32'(ev.released));
        check_equal("break codes code", 32'(code), 32'(ev.code));
        wait_cycles(2);
        check_equal("break codes seg_lo", 32'(seg_glyph(other[3:0])), 32'(seg_lo));
        check_equal("break codes seg_hi", 32'(seg_glyph(other[7:4])), 32'(seg_hi));
    endtask

    task automatic reject_bad_frames();
        send_frame(8'h1C, 1'b1, 11);
        catch_frame_error(1, "bad parity");
        wait_cycles(20);
        check_equal("bad parity events", 32'd0, 32'(ev_q.size()));
        // partial frame is left to time out inside the receiver
        send_frame(8'h00, 1'b0, 4);
        wait_cycles(IDLE_TIMEOUT + 100);
        check_equal("partial frame errors", 32'd1, 32'(err_pulses));
        check_equal("partial frame events", 32'd0, 32'(ev_q.size()));
        send_frame(8'h2B, 1'b0, 11);
        expect_make(8'h2B, "after partial frame");
    endtask

    task automatic stream_back_to_back();
        ps2_pkg::key_event_t ev;
        logic [7:0]          codes[8];
        int                  i;
        for (i = 0; i < 8; i++)
        begin
            codes[i] = random_code();
            send_frame(codes[i], 1'b0, 11);
        end
        for (i = 0; i < 8; i++)
        begin
            next_event(ev, "back to back");
            check_equal("back to back released", 32'(1'b0), 32'(ev.released));
            check_equal("back to back code", 32'(codes[i]), 32'(ev.code));
        end
        check_equal("back to back overflow", 32'(1'b0), 32'(overflow));
    endtask

    initial
    begin
        void'($urandom(32'hafcf_00ab));
        err_pulses = 0;
        rst     <= 1'b0;
        ps2_clk <= 1'b1;
        ps2_dat <= 1'b1;
        wait_cycles(10);
        rst <= 1'b1;
        wait_cycles(2);

        verify_reset_state();
        decode_make_codes();
        decode_break_codes();
        reject_bad_frames();
        stream_back_to_back();

        wait_cycles(50);
        check_equal("leftover events", 32'd0, 32'(ev_q.size()));
        check_equal("total frame errors", 32'd1, 32'(err_pulses));
        $display("All tests passed");
        $finish;
    end

endmodule

//--- compile.f
logic/ps2_pkg.sv
logic/ps2_frame_rx.sv
logic/scan_fifo.sv
logic/key_decoder.sv
logic/seg7_display.sv
logic/ps2_key_top.sv
verif/ps2_key_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= ps2_key_tb
FLAGS     ?= --binary --timing -Wno-fatal
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# the simulation binary exits non-zero on $fatal, so make fails with it
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f compile.f
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
